// File: versat_macros.svh
`ifndef VERSAT_MACROS_SVH
`define VERSAT_MACROS_SVH

// Operand and result word width.
`define DATA_W 16

// Address width of every local memory.
`define MEM_ADDR_W 6

// Accumulation period and iteration count widths.
`define PERIOD_W 4
`define ITER_W 6

// Start delay width of each unit.
`define DELAY_W 5

// Host configuration write data.
`define CFG_DATA_W 16

`endif

// File: versat_pkg.sv
package versat_pkg;

   // -------------------------------------------------------------------
   // Multiply-accumulate opcodes
   // -------------------------------------------------------------------

   // Slot 0 always loads the product.
   typedef enum logic {
      op_macc = 1'b0,
      op_msub = 1'b1
   } muladd_op_t;

   // -------------------------------------------------------------------
   // Configuration register map
   // -------------------------------------------------------------------
   typedef enum logic [3:0] {
      reg_opcode     = 4'd0,
      reg_iterations = 4'd1,
      reg_period     = 4'd2,
      reg_rd0_delay  = 4'd3,
      reg_rd1_delay  = 4'd4,
      reg_mac_delay  = 4'd5,
      reg_wr_delay   = 4'd6,
      reg_rd0_base   = 4'd7,
      reg_rd1_base   = 4'd8,
      reg_wr_base    = 4'd9
   } cfg_addr_t;

endpackage

// File: config_regs.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module config_regs (
   input  logic                         clk,
   input  logic                         rst,

   // Host write port.
   input  logic                         cfg_we,
   input  versat_pkg::cfg_addr_t        cfg_addr,
   input  logic [`CFG_DATA_W-1:0]       cfg_data,

   // Configuration levels to the units.
   output versat_pkg::muladd_op_t       opcode,
   output logic [`ITER_W-1:0]           iterations,
   output logic [`PERIOD_W-1:0]         period,
   output logic [`DELAY_W-1:0]          rd0_delay,
   output logic [`DELAY_W-1:0]          rd1_delay,
   output logic [`DELAY_W-1:0]          mac_delay,
   output logic [`DELAY_W-1:0]          wr_delay,
   output logic [`MEM_ADDR_W-1:0]       rd0_base,
   output logic [`MEM_ADDR_W-1:0]       rd1_base,
   output logic [`MEM_ADDR_W-1:0]       wr_base
);

   // -------------------------------------------------------------------
   // Register file
   // -------------------------------------------------------------------

   // Each field takes the low bits of the write data.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         opcode     <= versat_pkg::op_macc;
         iterations <= '0;
         period     <= '0;
         rd0_delay  <= '0;
         rd1_delay  <= '0;
         mac_delay  <= '0;
         wr_delay   <= '0;
         rd0_base   <= '0;
         rd1_base   <= '0;
         wr_base    <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            versat_pkg::reg_opcode: begin
               opcode <= versat_pkg::muladd_op_t'(cfg_data[0]);
            end
            versat_pkg::reg_iterations: begin
               iterations <= cfg_data[`ITER_W-1:0];
            end
            versat_pkg::reg_period: begin
               period <= cfg_data[`PERIOD_W-1:0];
            end
            versat_pkg::reg_rd0_delay: begin
               rd0_delay <= cfg_data[`DELAY_W-1:0];
            end
            versat_pkg::reg_rd1_delay: begin
               rd1_delay <= cfg_data[`DELAY_W-1:0];
            end
            versat_pkg::reg_mac_delay: begin
               mac_delay <= cfg_data[`DELAY_W-1:0];
            end
            versat_pkg::reg_wr_delay: begin
               wr_delay <= cfg_data[`DELAY_W-1:0];
            end
            versat_pkg::reg_rd0_base: begin
               rd0_base <= cfg_data[`MEM_ADDR_W-1:0];
            end
            versat_pkg::reg_rd1_base: begin
               rd1_base <= cfg_data[`MEM_ADDR_W-1:0];
            end
            versat_pkg::reg_wr_base: begin
               wr_base <= cfg_data[`MEM_ADDR_W-1:0];
            end
            default: begin
               // Unmapped addresses are ignored.
            end
         endcase
      end
   end

endmodule

// File: stream_read.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module stream_read (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,

   // Host write port into the local memory.
   input  logic                         mem_we,
   input  logic [`MEM_ADDR_W-1:0]       mem_addr,
   input  logic signed [`DATA_W-1:0]    mem_wdata,

   // Configuration.
   input  logic [`MEM_ADDR_W-1:0]       base,
   input  logic [`DELAY_W-1:0]          delay,
   input  logic [`ITER_W-1:0]           iterations,
   input  logic [`PERIOD_W-1:0]         period,

   // Operand stream.
   output logic signed [`DATA_W-1:0]    data,
   output logic                         done
);

   localparam int depth = 1 << `MEM_ADDR_W;

   logic signed [`DATA_W-1:0]           mem [0:depth-1];

   logic                                busy;
   logic [`DELAY_W-1:0]                 dly_cnt;
   logic [`ITER_W+`PERIOD_W-1:0]        total;
   logic [`ITER_W+`PERIOD_W-1:0]        idx;
   logic [`ITER_W+`PERIOD_W-1:0]        idx_next;
   logic [`MEM_ADDR_W-1:0]              rd_addr;

   // Number of elements in one run.
   assign total    = iterations * period;
   assign idx_next = idx + 1'b1;
   assign rd_addr  = base + idx[`MEM_ADDR_W-1:0];

   // -------------------------------------------------------------------
   // Address generator
   // -------------------------------------------------------------------

   // One address per cycle once the delay has expired.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy    <= 1'b0;
         dly_cnt <= '0;
         idx     <= '0;
         done    <= 1'b0;
      end else if (run) begin
         busy    <= 1'b1;
         dly_cnt <= delay;
         idx     <= '0;
         done    <= 1'b0;
      end else if (busy) begin
         if (dly_cnt != '0) begin
            dly_cnt <= dly_cnt - 1'b1;
         end else begin
            idx <= idx_next;
            // Also ends a run that has no elements at all.
            if (idx_next >= total) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // -------------------------------------------------------------------
   // Local memory
   // -------------------------------------------------------------------

   // Synchronous read, data follows the address by one cycle.
   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end
      data <= mem[rd_addr];
   end

endmodule

// File: muladd.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module muladd (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,

   // Operand streams.
   input  logic signed [`DATA_W-1:0]    in0,
   input  logic signed [`DATA_W-1:0]    in1,

   // Configuration.
   input  versat_pkg::muladd_op_t       opcode,
   input  logic [`ITER_W-1:0]           iterations,
   input  logic [`PERIOD_W-1:0]         period,
   input  logic [`DELAY_W-1:0]          delay0,

   // Accumulated result.
   output logic signed [`DATA_W-1:0]    out0,
   output logic                         done
);

   logic [`DELAY_W:0]                   dly_cnt;
   logic [`ITER_W-1:0]                  cur_iter;
   logic [`PERIOD_W-1:0]                cur_period;
   logic [`ITER_W:0]                    iter_next;
   logic [`PERIOD_W:0]                  period_next;

   logic signed [`DATA_W-1:0]           in0_reg;
   logic signed [`DATA_W-1:0]           in1_reg;
   logic signed [2*`DATA_W-1:0]         product;
   logic signed [2*`DATA_W-1:0]         acc;
   logic signed [2*`DATA_W-1:0]         acc_out;

   // One bit wider so the wrap compare cannot overflow.
   assign iter_next   = cur_iter + 1'b1;
   assign period_next = cur_period + 1'b1;

   // -------------------------------------------------------------------
   // Period and iteration control
   // -------------------------------------------------------------------

   // Two extra delay cycles cover the input and product registers.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done       <= 1'b0;
         dly_cnt    <= '0;
         cur_iter   <= '0;
         cur_period <= '0;
      end else if (run) begin
         dly_cnt <= delay0 + 2'd2;
         done    <= 1'b0;
      end else if (dly_cnt != '0) begin
         dly_cnt <= dly_cnt - 1'b1;
         if (iterations == '0) begin
            done <= 1'b1;
         end
         cur_iter   <= '0;
         cur_period <= '0;
      end else if (!done) begin
         cur_period <= period_next[`PERIOD_W-1:0];
         if (period_next >= period) begin
            cur_period <= '0;
            cur_iter   <= iter_next[`ITER_W-1:0];
            if (iter_next >= iterations) begin
               done <= 1'b1;
            end
         end
      end
   end

   // -------------------------------------------------------------------
   // Multiply-accumulate datapath
   // -------------------------------------------------------------------

   // Slot 0 reloads the accumulator with a fresh product.
   always_ff @(posedge clk) begin
      in0_reg <= in0;
      in1_reg <= in1;
      product <= in0_reg * in1_reg;
      if (cur_period == '0) begin
         acc <= product;
      end else if (opcode == versat_pkg::op_macc) begin
         acc <= acc + product;
      end else begin
         acc <= acc - product;
      end
      acc_out <= acc;
   end

   // Truncated to the word width.
   assign out0 = acc_out[`DATA_W-1:0];

endmodule

// File: stream_write.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module stream_write (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,

   // Result stream.
   input  logic signed [`DATA_W-1:0]    in0,

   // Configuration.
   input  logic [`MEM_ADDR_W-1:0]       base,
   input  logic [`DELAY_W-1:0]          delay,
   input  logic [`ITER_W-1:0]           iterations,
   input  logic [`PERIOD_W-1:0]         period,

   // Host read port.
   input  logic [`MEM_ADDR_W-1:0]       res_addr,
   output logic signed [`DATA_W-1:0]    res_rdata,
   output logic                         done
);

   localparam int depth = 1 << `MEM_ADDR_W;

   logic signed [`DATA_W-1:0]           mem [0:depth-1];

   logic                                busy;
   logic [`DELAY_W-1:0]                 dly_cnt;
   logic [`PERIOD_W-1:0]                slot;
   logic [`ITER_W-1:0]                  iter;
   logic [`PERIOD_W:0]                  slot_next;
   logic [`ITER_W:0]                    iter_next;
   logic                                wr_req;
   logic                                wr_last;
   logic [`MEM_ADDR_W-1:0]              wr_addr;

   assign slot_next = slot + 1'b1;
   assign iter_next = iter + 1'b1;

   // -------------------------------------------------------------------
   // Write address generator
   // -------------------------------------------------------------------

   // The write request is registered and lands one cycle after slot 0.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy    <= 1'b0;
         dly_cnt <= '0;
         slot    <= '0;
         iter    <= '0;
         wr_req  <= 1'b0;
         wr_last <= 1'b0;
         wr_addr <= '0;
         done    <= 1'b0;
      end else begin
         wr_req <= 1'b0;
         if (wr_req && wr_last) begin
            done <= 1'b1;
         end
         if (run) begin
            busy    <= 1'b1;
            dly_cnt <= delay;
            slot    <= '0;
            iter    <= '0;
            done    <= 1'b0;
         end else if (busy) begin
            if (dly_cnt != '0) begin
               dly_cnt <= dly_cnt - 1'b1;
            end else if (iterations == '0) begin
               busy <= 1'b0;
               done <= 1'b1;
            end else begin
               if (slot == '0) begin
                  wr_req  <= 1'b1;
                  wr_addr <= base + iter;
                  wr_last <= (iter_next >= iterations);
               end
               if (slot_next >= period) begin
                  slot <= '0;
                  iter <= iter_next[`ITER_W-1:0];
                  if (iter_next >= iterations) begin
                     busy <= 1'b0;
                  end
               end else begin
                  slot <= slot_next[`PERIOD_W-1:0];
               end
            end
         end
      end
   end

   // Result memory with a registered host read.
   always_ff @(posedge clk) begin
      if (wr_req) begin
         mem[wr_addr] <= in0;
      end
      res_rdata <= mem[res_addr];
   end

endmodule

// File: versat_engine.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module versat_engine (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,

   // Configuration writes.
   input  logic                         cfg_we,
   input  versat_pkg::cfg_addr_t        cfg_addr,
   input  logic [`CFG_DATA_W-1:0]       cfg_data,

   // Operand memory writes, mem_sel picks memory 0 or 1.
   input  logic                         mem_we,
   input  logic                         mem_sel,
   input  logic [`MEM_ADDR_W-1:0]       mem_addr,
   input  logic signed [`DATA_W-1:0]    mem_wdata,

   // Result readback.
   input  logic [`MEM_ADDR_W-1:0]       res_addr,
   output logic signed [`DATA_W-1:0]    res_rdata,
   output logic                         done
);

   versat_pkg::muladd_op_t              opcode;
   logic [`ITER_W-1:0]                  iterations;
   logic [`PERIOD_W-1:0]                period;
   logic [`DELAY_W-1:0]                 rd0_delay;
   logic [`DELAY_W-1:0]                 rd1_delay;
   logic [`DELAY_W-1:0]                 mac_delay;
   logic [`DELAY_W-1:0]                 wr_delay;
   logic [`MEM_ADDR_W-1:0]              rd0_base;
   logic [`MEM_ADDR_W-1:0]              rd1_base;
   logic [`MEM_ADDR_W-1:0]              wr_base;

   logic signed [`DATA_W-1:0]           rd0_data;
   logic signed [`DATA_W-1:0]           rd1_data;
   logic signed [`DATA_W-1:0]           mac_out;
   logic                                rd0_done;
   logic                                rd1_done;
   logic                                mac_done;
   logic                                wr_done;

   // -------------------------------------------------------------------
   // Units
   // -------------------------------------------------------------------
   config_regs i_config_regs (
      .clk, .rst, .cfg_we, .cfg_addr, .cfg_data,
      .opcode, .iterations, .period,
      .rd0_delay, .rd1_delay, .mac_delay, .wr_delay,
      .rd0_base, .rd1_base, .wr_base
   );

   stream_read i_stream_read0 (
      .clk, .rst, .run,
      .mem_we(mem_we & ~mem_sel), .mem_addr, .mem_wdata,
      .base(rd0_base), .delay(rd0_delay), .iterations, .period,
      .data(rd0_data), .done(rd0_done)
   );

   stream_read i_stream_read1 (
      .clk, .rst, .run,
      .mem_we(mem_we & mem_sel), .mem_addr, .mem_wdata,
      .base(rd1_base), .delay(rd1_delay), .iterations, .period,
      .data(rd1_data), .done(rd1_done)
   );

   muladd i_muladd (
      .clk, .rst, .run, .in0(rd0_data), .in1(rd1_data),
      .opcode, .iterations, .period, .delay0(mac_delay),
      .out0(mac_out), .done(mac_done)
   );

   stream_write i_stream_write (
      .clk, .rst, .run, .in0(mac_out),
      .base(wr_base), .delay(wr_delay), .iterations, .period,
      .res_addr, .res_rdata, .done(wr_done)
   );

   // Finished when every unit is.
   assign done = rd0_done & rd1_done & mac_done & wr_done;

endmodule

// File: tb_versat_engine.sv
`timescale 1ns/100ps
`include "versat_macros.svh"

module tb_versat_engine;

   localparam int depth = 1 << `MEM_ADDR_W;
   localparam int num_tests = 6;

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         run;
   logic                         cfg_we;
   versat_pkg::cfg_addr_t        cfg_addr;
   logic [`CFG_DATA_W-1:0]       cfg_data;
   logic                         mem_we;
   logic                         mem_sel;
   logic [`MEM_ADDR_W-1:0]       mem_addr;
   logic signed [`DATA_W-1:0]    mem_wdata;
   logic [`MEM_ADDR_W-1:0]       res_addr;
   logic signed [`DATA_W-1:0]    res_rdata;
   logic                         done;

   // Test table stored as one array per column.
   string                        t_name [0:num_tests-1];
   versat_pkg::muladd_op_t       t_op [0:num_tests-1];
   int                           t_iter [0:num_tests-1];
   int                           t_period [0:num_tests-1];
   int                           t_base0 [0:num_tests-1];
   int                           t_base1 [0:num_tests-1];
   int                           t_wbase [0:num_tests-1];

   // Operand copies and the expected result memory.
   logic signed [`DATA_W-1:0]    op_a [0:depth-1];
   logic signed [`DATA_W-1:0]    op_b [0:depth-1];
   logic signed [`DATA_W-1:0]    res_model [0:depth-1];
   bit                           res_valid [0:depth-1];
   logic signed [`DATA_W-1:0]    word;
   logic [15:0]                  lfsr;
   int                           cycle_count = 0;
   int                           timeout_limit = 0;

   versat_engine i_versat_engine (
      .clk, .rst, .run, .cfg_we, .cfg_addr, .cfg_data,
      .mem_we, .mem_sel, .mem_addr, .mem_wdata,
      .res_addr, .res_rdata, .done
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         fail_stop("Timeout: done never came within the cycle limit.");
      end
   end

   // -------------------------------------------------------------------
   // Checks and helpers
   // -------------------------------------------------------------------
   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_result(input string name, input logic signed [`DATA_W-1:0] expected,
                               input logic signed [`DATA_W-1:0] actual);
      if (actual !== expected) begin
         fail_stop($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
      end
   endtask

   task automatic check_done(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         fail_stop($sformatf("[ERROR] %s: expected done %0b, actual %0b",
                             name, expected, actual));
      end
   endtask

   // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_word(output logic signed [`DATA_W-1:0] w);
      for (int b = 0; b < `DATA_W; b++) begin
         lfsr = lfsr_step(lfsr);
         w = {w[`DATA_W-2:0], lfsr[0]};
      end
   endtask

   task automatic set_entry(input int t, input string name, input versat_pkg::muladd_op_t op,
                            input int it, input int per, input int b0, input int b1,
                            input int bw);
      t_name[t] = name;
      t_op[t] = op;
      t_iter[t] = it;
      t_period[t] = per;
      t_base0[t] = b0;
      t_base1[t] = b1;
      t_wbase[t] = bw;
   endtask

   task automatic write_mem(input logic sel, input int a, input logic signed [`DATA_W-1:0] w);
      @(posedge clk);
      mem_we <= 1'b1;
      mem_sel <= sel;
      mem_addr <= a[`MEM_ADDR_W-1:0];
      mem_wdata <= w;
      if (sel) begin
         op_b[a] = w;
      end else begin
         op_a[a] = w;
      end
   endtask

   task automatic write_cfg(input versat_pkg::cfg_addr_t a, input int d);
      @(posedge clk);
      cfg_we <= 1'b1;
      cfg_addr <= a;
      cfg_data <= d[`CFG_DATA_W-1:0];
   endtask

   // Expected results from the accumulation rule.
   task automatic update_model(input int t);
      logic signed [2*`DATA_W-1:0] acc;
      int ia;
      int ib;
      for (int i = 0; i < t_iter[t]; i++) begin
         for (int p = 0; p < t_period[t]; p++) begin
            ia = (t_base0[t] + i * t_period[t] + p) % depth;
            ib = (t_base1[t] + i * t_period[t] + p) % depth;
            if (p == 0) begin
               acc = op_a[ia] * op_b[ib];
            end else if (t_op[t] == versat_pkg::op_macc) begin
               acc = acc + op_a[ia] * op_b[ib];
            end else begin
               acc = acc - op_a[ia] * op_b[ib];
            end
         end
         res_model[(t_wbase[t] + i) % depth] = acc[`DATA_W-1:0];
         res_valid[(t_wbase[t] + i) % depth] = 1'b1;
      end
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial begin
      rst = 1'b1;
      run = 1'b0;
      cfg_we = 1'b0;
      cfg_addr = versat_pkg::reg_opcode;
      cfg_data = '0;
      mem_we = 1'b0;
      mem_sel = 1'b0;
      mem_addr = '0;
      mem_wdata = '0;
      res_addr = '0;
      lfsr = 16'd18240;

      set_entry(0, "macc_p4", versat_pkg::op_macc, 6, 4, 0, 0, 0);
      set_entry(1, "msub_p3", versat_pkg::op_msub, 5, 3, 24, 30, 8);
      set_entry(2, "period_1", versat_pkg::op_macc, 8, 1, 40, 50, 16);
      set_entry(3, "iter_zero", versat_pkg::op_macc, 0, 2, 0, 0, 8);
      set_entry(4, "b2b_first", versat_pkg::op_msub, 4, 5, 10, 3, 24);
      set_entry(5, "b2b_second", versat_pkg::op_macc, 3, 2, 5, 33, 30);

      // Fill, delays, stream length and readback of every entry.
      timeout_limit = 2 * depth + 200;
      for (int t = 0; t < num_tests; t++) begin
         timeout_limit += 1 + t_period[t] + 3 + t_iter[t] * t_period[t] + 20 + 3 * depth;
      end

      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_done("after_reset", 1'b0, done);

      for (int a = 0; a < depth; a++) begin
         random_word(word);
         write_mem(1'b0, a, word);
         random_word(word);
         write_mem(1'b1, a, word);
      end
      // Extreme operands in the MSUB region.
      write_mem(1'b0, 24, 16'sh8000);
      write_mem(1'b1, 30, 16'sh8000);
      write_mem(1'b0, 25, 16'sh7fff);
      @(posedge clk);
      mem_we <= 1'b0;

      for (int t = 0; t < num_tests; t++) begin
         write_cfg(versat_pkg::reg_opcode, t_op[t]);
         write_cfg(versat_pkg::reg_iterations, t_iter[t]);
         write_cfg(versat_pkg::reg_period, t_period[t]);
         write_cfg(versat_pkg::reg_rd0_delay, 0);
         write_cfg(versat_pkg::reg_rd1_delay, 0);
         write_cfg(versat_pkg::reg_mac_delay, 1);
         write_cfg(versat_pkg::reg_wr_delay, t_period[t] + 3);
         write_cfg(versat_pkg::reg_rd0_base, t_base0[t]);
         write_cfg(versat_pkg::reg_rd1_base, t_base1[t]);
         write_cfg(versat_pkg::reg_wr_base, t_wbase[t]);
         @(posedge clk);
         cfg_we <= 1'b0;
         run <= 1'b1;
         @(posedge clk);
         run <= 1'b0;
         @(negedge clk);
         check_done({t_name[t], " after run"}, 1'b0, done);
         while (done !== 1'b1) begin
            @(negedge clk);
         end

         // Read back every known word including untouched ones.
         update_model(t);
         for (int a = 0; a < depth; a++) begin
            if (res_valid[a]) begin
               @(posedge clk);
               res_addr <= a[`MEM_ADDR_W-1:0];
               @(posedge clk);
               @(negedge clk);
               check_result($sformatf("%s addr %0d", t_name[t], a), res_model[a], res_rdata);
            end
         end
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: sim.f
+incdir+.
versat_pkg.sv
config_regs.sv
stream_read.sv
muladd.sv
stream_write.sv
versat_engine.sv
tb_versat_engine.sv
